// ==== hdl/rel_stream_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream types for the rel buffer
// Data word, TMR handshake, stage count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rel_stream_pkg;

  // Width of one stream data word
  localparam int unsigned WordWidth = 32;

  // Each handshake signal is carried in three redundant lanes
  localparam int unsigned HsWidth = 3;

  // Spill stages chained inside the buffer
  localparam int unsigned NumStages = 2;

  // One data word of the stream
  typedef logic [WordWidth-1:0] word_t;

  // One handshake signal, bit i is lane i
  typedef logic [HsWidth-1:0] hs_t;

endpackage

// ==== hdl/rel_csr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register map for the buffer
// Bus structs, offsets, status layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rel_csr_pkg;

  // Byte offset into the register block
  typedef logic [7:0] reg_addr_t;

  // Register and bus data word
  typedef logic [31:0] reg_data_t;

  // APB request from the master
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    reg_addr_t paddr;
    reg_data_t pwdata;
  } apb_req_t;

  // APB response from the register block
  typedef struct packed {
    reg_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Register offsets
  localparam reg_addr_t StatusOffset = 8'h00;
  localparam reg_addr_t CountOffset  = 8'h04;
  localparam reg_addr_t IdOffset     = 8'h08;

  // Stage s reports its sticky fault at this bit plus s
  localparam int unsigned StatusFaultLsb = 0;

endpackage

// ==== hdl/tmr_voter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bitwise triple majority voter
// Flags any lane disagreement
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tmr_voter #(
  // Number of bits voted in parallel
  parameter int Width = 1
) (
  input  logic [Width-1:0] a_i,
  input  logic [Width-1:0] b_i,
  input  logic [Width-1:0] c_i,
  output logic [Width-1:0] majority_o,
  output logic             fault_o
);

  // Per bit, high where at least one copy differs from the others
  logic [Width-1:0] mismatch;

  // Each output bit takes the value shared by two or three copies
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // If a agrees with both b and c, all three are equal on that bit
  assign mismatch = (a_i ^ b_i) | (a_i ^ c_i);

  // A single differing bit anywhere is enough to report a fault
  assign fault_o = |mismatch;

endmodule

// ==== hdl/rel_spill_register.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Spill register, TMR handshake
// Two slots, triplicated full flags,
// voted data path and fault output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rel_spill_register #(
  // Turns the stage into plain wires
  parameter bit Bypass = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rel_stream_pkg::hs_t   valid_i,
  output rel_stream_pkg::hs_t   ready_o,
  input  rel_stream_pkg::word_t data_i,
  output rel_stream_pkg::hs_t   valid_o,
  input  rel_stream_pkg::hs_t   ready_i,
  output rel_stream_pkg::word_t data_o,
  output logic                  fault_o
);

  import rel_stream_pkg::*;

  if (Bypass) begin : gen_bypass
    // Zero latency, nothing stored so nothing can disagree
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
    assign fault_o = 1'b0;
  end else begin : gen_spill
    // Bit 0 A data, bits 1-3 A full, bits 4-6 B full, 7 B data, 8 output data
    logic [8:0] faults;

    // Slot A takes new words from upstream
    word_t a_data_q;
    word_t a_data_d;
    word_t a_data_d_tmr [3];
    hs_t   a_full_tmr_q;
    hs_t   a_full_q;
    hs_t   a_fill;
    hs_t   a_drain;

    // Slot B holds the older word while downstream stalls
    word_t b_data_q;
    word_t b_data_d;
    word_t b_data_d_tmr [3];
    hs_t   b_full_tmr_q;
    hs_t   b_full_q;
    hs_t   b_fill;
    hs_t   b_drain;

    // Output selection as each lane sees it
    word_t data_o_tmr [3];

    assign fault_o = |faults;

    for (genvar i = 0; i < 3; i++) begin : gen_lane
      // Lane i accepts a word on its own handshake
      assign a_fill[i]  = valid_i[i] && ready_o[i];
      // A empties whenever it holds a word and B is free to take over
      assign a_drain[i] = a_full_q[i] && !b_full_q[i];
      // The word leaving A is parked in B if downstream stalls
      assign b_fill[i]  = a_drain[i] && !ready_i[i];
      assign b_drain[i] = b_full_q[i] && ready_i[i];

      // Room is left as long as one slot is free, no dependence on ready_i
      assign ready_o[i] = !a_full_q[i] || !b_full_q[i];
      assign valid_o[i] = a_full_q[i] || b_full_q[i];

      // Next state and output selection, computed per lane then voted
      assign a_data_d_tmr[i] = a_fill[i] ? data_i : a_data_q;
      assign b_data_d_tmr[i] = b_fill[i] ? a_data_q : b_data_q;
      // B always holds the older word, so it goes out first
      assign data_o_tmr[i]   = b_full_q[i] ? b_data_q : a_data_q;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          a_full_tmr_q[i] <= 1'b0;
        end else if (a_fill[i] || a_drain[i]) begin
          a_full_tmr_q[i] <= a_fill[i];
        end
      end

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          b_full_tmr_q[i] <= 1'b0;
        end else if (b_fill[i] || b_drain[i]) begin
          b_full_tmr_q[i] <= b_fill[i];
        end
      end

      // Every lane gets its own voter so no single gate feeds all three
      tmr_voter #(.Width(1)) u_a_full_voter (
        .a_i        (a_full_tmr_q[0]),
        .b_i        (a_full_tmr_q[1]),
        .c_i        (a_full_tmr_q[2]),
        .majority_o (a_full_q[i]),
        .fault_o    (faults[1+i])
      );

      tmr_voter #(.Width(1)) u_b_full_voter (
        .a_i        (b_full_tmr_q[0]),
        .b_i        (b_full_tmr_q[1]),
        .c_i        (b_full_tmr_q[2]),
        .majority_o (b_full_q[i]),
        .fault_o    (faults[4+i])
      );
    end

    tmr_voter #(.Width(WordWidth)) u_a_data_voter (
      .a_i        (a_data_d_tmr[0]),
      .b_i        (a_data_d_tmr[1]),
      .c_i        (a_data_d_tmr[2]),
      .majority_o (a_data_d),
      .fault_o    (faults[0])
    );

    tmr_voter #(.Width(WordWidth)) u_b_data_voter (
      .a_i        (b_data_d_tmr[0]),
      .b_i        (b_data_d_tmr[1]),
      .c_i        (b_data_d_tmr[2]),
      .majority_o (b_data_d),
      .fault_o    (faults[7])
    );

    tmr_voter #(.Width(WordWidth)) u_out_data_voter (
      .a_i        (data_o_tmr[0]),
      .b_i        (data_o_tmr[1]),
      .c_i        (data_o_tmr[2]),
      .majority_o (data_o),
      .fault_o    (faults[8])
    );

    // Slots load the voted next state on every edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        a_data_q <= '0;
        b_data_q <= '0;
      end else begin
        a_data_q <= a_data_d;
        b_data_q <= b_data_d;
      end
    end
  end

endmodule

// ==== hdl/rel_fault_csr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB fault register block
// Sticky stage faults, word count, ID
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rel_fault_csr (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  rel_csr_pkg::apb_req_t                apb_req_i,
  output rel_csr_pkg::apb_rsp_t                apb_rsp_o,
  input  logic [rel_stream_pkg::NumStages-1:0] fault_i,
  input  logic                                 out_xfer_i
);

  import rel_csr_pkg::*;
  import rel_stream_pkg::*;

  logic                 apb_access;
  logic                 apb_write;
  logic                 status_hit;
  logic                 count_hit;
  logic [NumStages-1:0] status_q;
  logic [NumStages-1:0] status_clr;
  reg_data_t            count_q;

  // The access phase is the only one that reads or writes
  assign apb_access = apb_req_i.psel && apb_req_i.penable;
  assign apb_write  = apb_access && apb_req_i.pwrite;

  assign status_hit = apb_req_i.paddr == StatusOffset;
  assign count_hit  = apb_req_i.paddr == CountOffset;

  // Writing 1 clears a status bit, writing 0 leaves it alone
  assign status_clr = (apb_write && status_hit) ?
                      apb_req_i.pwdata[StatusFaultLsb +: NumStages] : '0;

  // A fault in the same cycle as a clear keeps the bit set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | fault_i;
    end
  end

  // Any write to the count register restarts it from zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (apb_write && count_hit) begin
      count_q <= '0;
    end else if (out_xfer_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Read data and error are ready in the access phase, no wait states
  always_comb begin
    apb_rsp_o        = '0;
    apb_rsp_o.pready = 1'b1;
    case (apb_req_i.paddr)
      StatusOffset: begin
        apb_rsp_o.prdata[StatusFaultLsb +: NumStages] = status_q;
      end
      CountOffset: begin
        apb_rsp_o.prdata = count_q;
      end
      IdOffset: begin
        // Read only, writes here are accepted and dropped
        apb_rsp_o.prdata = reg_data_t'(NumStages);
      end
      default: begin
        apb_rsp_o.pslverr = apb_access;
      end
    endcase
  end

endmodule

// ==== hdl/rel_stream_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fault tolerant stream buffer
// Two TMR spill stages, APB status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rel_stream_buffer #(
  // Applied to both spill stages
  parameter bit Bypass = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rel_stream_pkg::hs_t   valid_i,
  output rel_stream_pkg::hs_t   ready_o,
  input  rel_stream_pkg::word_t data_i,
  output rel_stream_pkg::hs_t   valid_o,
  input  rel_stream_pkg::hs_t   ready_i,
  output rel_stream_pkg::word_t data_o,
  input  rel_csr_pkg::apb_req_t apb_req_i,
  output rel_csr_pkg::apb_rsp_t apb_rsp_o
);

  import rel_stream_pkg::*;

  // Link between stage 0 and stage 1
  hs_t                  mid_valid;
  hs_t                  mid_ready;
  word_t                mid_data;
  // Per lane handshake at the buffer output
  hs_t                  out_hs;
  logic                 out_xfer;
  logic [NumStages-1:0] stage_fault;

  rel_spill_register #(.Bypass(Bypass)) u_stage0 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .valid_o (mid_valid),
    .ready_i (mid_ready),
    .data_o  (mid_data),
    .fault_o (stage_fault[0])
  );

  rel_spill_register #(.Bypass(Bypass)) u_stage1 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (mid_valid),
    .ready_o (mid_ready),
    .data_i  (mid_data),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o),
    .fault_o (stage_fault[1])
  );

  // A word counts as delivered when two of three lanes complete the handshake
  assign out_hs   = valid_o & ready_i;
  assign out_xfer = (out_hs[0] & out_hs[1]) | (out_hs[0] & out_hs[2]) |
                    (out_hs[1] & out_hs[2]);

  rel_fault_csr u_csr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .fault_i    (stage_fault),
    .out_xfer_i (out_xfer)
  );

endmodule

// ==== bench/rel_stream_buffer_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the TMR stream buffer
// Runs stream, fault and APB tests from a file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rel_stream_buffer_tb;

  import rel_stream_pkg::*;
  import rel_csr_pkg::*;

  // Cycles any wait may take before the run is abandoned
  localparam int Timeout = 1000;
  // How long ready_o must stay low to count as a full buffer
  localparam int StallLimit = 32;

  logic     clk_i;
  logic     rst_ni;
  hs_t      valid_i;
  hs_t      ready_o;
  word_t    data_i;
  hs_t      valid_o;
  hs_t      ready_i;
  word_t    data_o;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  // Words accepted by the buffer and not yet seen at the output
  word_t sb[$];
  word_t exp_word;
  string cur_test;
  int    stall_pct;
  int    out_count;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;
  bit    aborted;

  rel_stream_buffer u_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (valid_i),
    .ready_o   (ready_o),
    .data_i    (data_i),
    .valid_o   (valid_o),
    .ready_i   (ready_i),
    .data_o    (data_o),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  always #10 clk_i = ~clk_i;

  // A handshake counts when at least two of its three lanes agree
  function automatic logic two_of_three(hs_t v);
    return (v[0] & v[1]) | (v[0] & v[2]) | (v[1] & v[2]);
  endfunction

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    assert (actual == expected) else begin
      $display("[ERROR] %s: %s expected %h, actual %h", cur_test, what, expected, actual);
      test_errors++;
    end
  endtask

  // Downstream stalls are redrawn every cycle from the current stall rate
  initial begin
    ready_i = '1;
    forever begin
      @(posedge clk_i);
      #2;
      ready_i = ($urandom_range(99, 0) < stall_pct) ? '0 : '1;
    end
  end

  // The output side is sampled mid cycle where the handshake is settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // Every lane reads the same voted flags, so one bad input lane never splits them
      assert (valid_o == '0 || valid_o == '1) else begin
        $display("[ERROR] %s: valid_o lanes expected all equal, actual %b",
                 cur_test, valid_o);
        test_errors++;
      end
      assert (ready_o == '0 || ready_o == '1) else begin
        $display("[ERROR] %s: ready_o lanes expected all equal, actual %b",
                 cur_test, ready_o);
        test_errors++;
      end
    end
    if (rst_ni && two_of_three(valid_o & ready_i)) begin
      out_count++;
      assert (sb.size() != 0) else begin
        $display("%s: a word left the buffer when none was expected", cur_test);
        test_errors++;
      end
      if (sb.size() != 0) begin
        exp_word = sb.pop_front();
        check_value("data_o", exp_word, data_o);
      end
    end
  end

  // Returns at a falling edge and sets got when ready_o came up
  task automatic wait_ready(input int limit, output bit got);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!two_of_three(ready_o) && waited < limit) begin
      waited++;
      @(negedge clk_i);
    end
    got = two_of_three(ready_o);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (sb.size() != 0) begin
      if (waited >= Timeout) begin
        $display("%s: timeout waiting for %0d words to leave", cur_test, sb.size());
        aborted = 1'b1;
        return;
      end
      @(posedge clk_i);
      #2;
      waited++;
    end
  endtask

  // Offers one word on the given lanes and records it once it is taken
  task automatic send_word(input hs_t lanes, input int limit, output bit got);
    word_t w;
    w = $urandom;
    valid_i = lanes;
    data_i = w;
    wait_ready(limit, got);
    if (got) begin
      @(posedge clk_i);
      sb.push_back(w);
      #2;
    end
  endtask

  task automatic run_stream(input int words, input int pct, input int expected);
    int start_count;
    int accepted;
    bit got;
    bit released;
    start_count = out_count;
    accepted = 0;
    released = 1'b0;
    stall_pct = pct;
    @(posedge clk_i);
    #2;
    for (int k = 0; k < words; k++) begin
      send_word('1, (pct >= 100 && !released) ? StallLimit : Timeout, got);
      if (!got && pct >= 100 && !released) begin
        // Nothing leaves while ready_i is low, so all accepted words are held
        check_value("words held", expected, accepted);
        released = 1'b1;
        stall_pct = 0;
        wait_ready(Timeout, got);
        @(posedge clk_i);
        sb.push_back(data_i);
        #2;
      end
      if (!got) begin
        $display("%s: timeout waiting for ready_o", cur_test);
        aborted = 1'b1;
        return;
      end
      accepted++;
    end
    valid_i = '0;
    wait_drain();
    stall_pct = 0;
    if (aborted) begin
      return;
    end
    if (pct >= 100) begin
      if (!released) begin
        check_value("words held", expected, accepted);
      end
      check_value("words out", words, out_count - start_count);
    end else begin
      check_value("words out", expected, out_count - start_count);
    end
  endtask

  // Sends one word with a lane out of step that the voters must hide
  task automatic run_inject(input hs_t lanes, input int expected);
    int start_count;
    bit got;
    start_count = out_count;
    send_word(lanes, Timeout, got);
    valid_i = '0;
    if (!got) begin
      $display("%s: timeout waiting for ready_o", cur_test);
      aborted = 1'b1;
      return;
    end
    wait_drain();
    if (!aborted) begin
      check_value("words out", expected, out_count - start_count);
    end
  endtask

  // Runs the setup and access phases and takes read data while the access is held
  task automatic apb_transfer(input bit write, input reg_addr_t addr, input reg_data_t wdata,
                              output reg_data_t rdata, output bit err);
    int waited;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = addr;
    apb_req.pwdata = wdata;
    @(posedge clk_i);
    #2;
    apb_req.penable = 1'b1;
    waited = 0;
    @(negedge clk_i);
    while (!apb_rsp.pready && waited < Timeout) begin
      waited++;
      @(negedge clk_i);
    end
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    if (!apb_rsp.pready) begin
      $display("%s: timeout waiting for pready", cur_test);
      aborted = 1'b1;
    end
    @(posedge clk_i);
    #2;
    apb_req = '0;
  endtask

  task automatic run_test(input string name, input string op,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
    reg_data_t rdata;
    bit err;
    cur_test = name;
    test_errors = 0;
    if (op == "stream") begin
      run_stream(a, b, exp);
    end else if (op == "inject") begin
      run_inject(a[2:0], exp);
    end else if (op == "apb_read") begin
      apb_transfer(1'b0, a[7:0], '0, rdata, err);
      check_value("pslverr", b, {31'b0, err});
      check_value("prdata", exp, rdata);
    end else if (op == "apb_write") begin
      apb_transfer(1'b1, a[7:0], b, rdata, err);
      check_value("pslverr", exp, {31'b0, err});
    end else begin
      $display("%s: unknown operation %s in the tests file", name, op);
      test_errors++;
    end
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0 && !aborted) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end
  endtask

  initial begin
    int fd;
    int n;
    string line;
    string name;
    string op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    void'($urandom(60396));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    valid_i = '0;
    data_i = '0;
    apb_req = '0;
    stall_pct = 0;
    out_count = 0;
    test_errors = 0;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    aborted = 1'b0;
    cur_test = "reset";
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // Both stages come out of reset empty with every lane ready
    check_value("valid_o", 32'h0, {29'b0, valid_o});
    check_value("ready_o", 32'h7, {29'b0, ready_o});
    total_errors += test_errors;
    fd = $fopen("bench/rel_stream_buffer_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the tests file");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Column notes and blank lines carry no test
      if (n > 0 && line[0] != "#") begin
        n = $sscanf(line, "%s %s %h %h %h", name, op, a, b, exp);
        if (n == 5) begin
          run_test(name, op, a, b, exp);
        end else if (n > 0) begin
          $display("malformed line in the tests file: %s", line);
          total_errors++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0 && tests_run > 0 && !aborted) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== rel_stream_buffer.f ====
hdl/rel_stream_pkg.sv
hdl/rel_csr_pkg.sv
hdl/tmr_voter.sv
hdl/rel_spill_register.sv
hdl/rel_fault_csr.sv
hdl/rel_stream_buffer.sv
bench/rel_stream_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rel_stream_buffer_tb \
  -f rel_stream_buffer.f \
  -o rel_stream_buffer_sim

sim_out=$(./obj_dir/rel_stream_buffer_sim)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'PASS: all tests'; then
  exit 0
fi
exit 1

// ==== bench/rel_stream_buffer_tests.txt ====
# name op arg_a arg_b expected, all numbers in hex
# stream: a=words, b=stall percent, expected=words out (100 percent: words held before ready_o drops)
# inject: a=valid lane mask; apb_read: a=offset, b=pslverr, expected=prdata; apb_write: a=offset, b=pwdata, expected=pslverr
reset_status apb_read 00 0 00000000
reset_count apb_read 04 0 00000000
read_id apb_read 08 0 00000002
read_unmapped apb_read 0c 1 00000000
write_unmapped apb_write 10 0 1
write_id_ignored apb_write 08 5 0
id_unchanged apb_read 08 0 00000002
stream_no_stall stream 10 0 10
count_after_burst apb_read 04 0 00000010
stream_random_stall stream 40 32 40
count_after_stall apb_read 04 0 00000050
stream_full_stall stream 0c 64 4
count_after_full apb_read 04 0 0000005c
status_clean apb_read 00 0 00000000
clear_count apb_write 04 0 0
count_cleared apb_read 04 0 00000000
inject_lane2_low inject 3 0 1
status_fault apb_read 00 0 00000001
clear_fault apb_write 00 1 0
status_cleared apb_read 00 0 00000000
inject_lane0_low inject 6 0 1
status_fault_again apb_read 00 0 00000001
count_after_inject apb_read 04 0 00000002
clear_count_any apb_write 04 deadbeef 0
count_zero apb_read 04 0 00000000
